// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing
TOP       := tb_idu
FILELIST  := verilog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== id_pkg.sv ====
`default_nettype none

package id_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [29:0] op_onehot_t;    // bit 29 is SPECIAL, bit 0 is SWR
    typedef logic [29:0] func_onehot_t;  // bit 29 is ADD, bit 0 is ERET

    localparam logic [5:0] SPECIAL_OP  = 6'b000000;
    localparam logic [5:0] SPECIAL2_OP = 6'b011100;
    localparam logic [5:0] COP0_OP     = 6'b010000;
    localparam logic [5:0] REGIMM_OP   = 6'b000001;
    localparam logic [5:0] ADDI_OP     = 6'b001000;
    localparam logic [5:0] ADDIU_OP    = 6'b001001;
    localparam logic [5:0] SLTI_OP     = 6'b001010;
    localparam logic [5:0] SLTIU_OP    = 6'b001011;
    localparam logic [5:0] ANDI_OP     = 6'b001100;
    localparam logic [5:0] LUI_OP      = 6'b001111;
    localparam logic [5:0] ORI_OP      = 6'b001101;
    localparam logic [5:0] XORI_OP     = 6'b001110;
    localparam logic [5:0] LB_OP       = 6'b100000;
    localparam logic [5:0] LH_OP       = 6'b100001;
    localparam logic [5:0] LBU_OP      = 6'b100100;
    localparam logic [5:0] LHU_OP      = 6'b100101;
    localparam logic [5:0] LW_OP       = 6'b100011;
    localparam logic [5:0] LWL_OP      = 6'b100010;
    localparam logic [5:0] LWR_OP      = 6'b100110;
    localparam logic [5:0] JAL_OP      = 6'b000011;
    localparam logic [5:0] BEQ_OP      = 6'b000100;
    localparam logic [5:0] BNE_OP      = 6'b000101;
    localparam logic [5:0] BGTZ_OP     = 6'b000111;
    localparam logic [5:0] BLEZ_OP     = 6'b000110;
    localparam logic [5:0] J_OP        = 6'b000010;
    localparam logic [5:0] SB_OP       = 6'b101000;
    localparam logic [5:0] SH_OP       = 6'b101001;
    localparam logic [5:0] SW_OP       = 6'b101011;
    localparam logic [5:0] SWL_OP      = 6'b101010;
    localparam logic [5:0] SWR_OP      = 6'b101110;

    localparam logic [5:0] ADD_FUNCT     = 6'b100000;
    localparam logic [5:0] ADDU_FUNCT    = 6'b100001;
    localparam logic [5:0] SUB_FUNCT     = 6'b100010;
    localparam logic [5:0] SUBU_FUNCT    = 6'b100011;
    localparam logic [5:0] SLT_FUNCT     = 6'b101010;
    localparam logic [5:0] SLTU_FUNCT    = 6'b101011;
    localparam logic [5:0] AND_FUNCT     = 6'b100100;
    localparam logic [5:0] NOR_FUNCT     = 6'b100111;
    localparam logic [5:0] OR_FUNCT      = 6'b100101;
    localparam logic [5:0] XOR_FUNCT     = 6'b100110;
    localparam logic [5:0] SLLV_FUNCT    = 6'b000100;
    localparam logic [5:0] SLL_FUNCT     = 6'b000000;
    localparam logic [5:0] SRAV_FUNCT    = 6'b000111;
    localparam logic [5:0] SRA_FUNCT     = 6'b000011;
    localparam logic [5:0] SRLV_FUNCT    = 6'b000110;
    localparam logic [5:0] SRL_FUNCT     = 6'b000010;
    localparam logic [5:0] JALR_FUNCT    = 6'b001001;
    localparam logic [5:0] MFHI_FUNCT    = 6'b010000;
    localparam logic [5:0] MFLO_FUNCT    = 6'b010010;
    localparam logic [5:0] DIV_FUNCT     = 6'b011010;
    localparam logic [5:0] DIVU_FUNCT    = 6'b011011;
    localparam logic [5:0] MUL_FUNCT     = 6'b000010;  // under SPECIAL2
    localparam logic [5:0] MULT_FUNCT    = 6'b011000;
    localparam logic [5:0] MULTU_FUNCT   = 6'b011001;
    localparam logic [5:0] JR_FUNCT      = 6'b001000;
    localparam logic [5:0] MTHI_FUNCT    = 6'b010001;
    localparam logic [5:0] MTLO_FUNCT    = 6'b010011;
    localparam logic [5:0] BREAK_FUNCT   = 6'b001101;
    localparam logic [5:0] SYSCALL_FUNCT = 6'b001100;
    localparam logic [5:0] ERET_FUNCT    = 6'b011000;  // under COP0 with the CO bit
    localparam logic [5:0] TLBP_FUNCT    = 6'b001000;
    localparam logic [5:0] TLBR_FUNCT    = 6'b000001;
    localparam logic [5:0] TLBWI_FUNCT   = 6'b000010;

    localparam logic [4:0] BGEZ_RT   = 5'b00001;
    localparam logic [4:0] BLTZ_RT   = 5'b00000;
    localparam logic [4:0] BGEZAL_RT = 5'b10001;
    localparam logic [4:0] BLTZAL_RT = 5'b10000;
    localparam logic [4:0] MFC0_RS   = 5'b00000;
    localparam logic [4:0] MTC0_RS   = 5'b00100;

    // positions in op_onehot_t that the immediate extension looks at
    localparam int ANDI_BIT = 21;
    localparam int LUI_BIT  = 20;
    localparam int ORI_BIT  = 19;
    localparam int XORI_BIT = 18;

    typedef struct packed {
        op_onehot_t   op_codes;
        func_onehot_t func_codes;
        reg_addr_t    rs;
        reg_addr_t    rt;
        reg_addr_t    rd;
        logic [4:0]   sa;
        logic [15:0]  imme;
        logic [25:0]  j_imme;
        logic         w_reg_ena;
        reg_addr_t    w_reg_dst;
        logic         is_branch;
        logic         is_j_imme;
        logic         is_jr;
        logic         is_ls;
        logic         is_mul;
        logic         is_cop0;
        logic         is_tlbp;
        logic         is_tlbr;
        logic         is_tlbwi;
        logic         is_check_ov;
        logic         is_ri;
        logic         is_hilo;
    } id_dec_t;

    typedef struct packed {
        logic      ena;
        reg_addr_t dst;
        word_t     data;
    } wb_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t dst;
    } load_hz_t;

    typedef struct packed {
        id_dec_t dec;
        word_t   rs_val;
        word_t   rt_val;
        word_t   imm_ext;
    } id_ex_t;

endpackage

`default_nettype wire

// ==== idu_1.sv ====
`default_nettype none

module idu_1 import id_pkg::*; (
    input  wire inst_t inst,
    output id_dec_t    dec
);
    logic [5:0]   op;
    logic [5:0]   funct;
    reg_addr_t    rs;
    reg_addr_t    rt;
    op_onehot_t   op_codes;
    func_onehot_t func_raw;
    func_onehot_t func_mask;
    func_onehot_t func_codes;
    logic         co_ctx;
    logic         mfc0;
    logic         mtc0;
    logic         regimm_ok;
    logic         link;
    logic         r_writer;
    logic         i_writer;
    reg_addr_t    w_dst;
    logic         tlbp;
    logic         tlbr;
    logic         tlbwi;

    assign op    = inst[31:26];
    assign funct = inst[5:0];
    assign rs    = inst[25:21];
    assign rt    = inst[20:16];

    assign op_codes = {
        op == SPECIAL_OP,
        op == SPECIAL2_OP,
        op == COP0_OP,
        op == REGIMM_OP,
        op == ADDI_OP,      // 25..18 are the ALU immediates
        op == ADDIU_OP,
        op == SLTI_OP,
        op == SLTIU_OP,
        op == ANDI_OP,
        op == LUI_OP,
        op == ORI_OP,
        op == XORI_OP,
        op == LB_OP,        // 17..11 are the loads
        op == LH_OP,
        op == LBU_OP,
        op == LHU_OP,
        op == LW_OP,
        op == LWL_OP,
        op == LWR_OP,
        op == JAL_OP,
        op == BEQ_OP,       // 9..6 are the compare branches
        op == BNE_OP,
        op == BGTZ_OP,
        op == BLEZ_OP,
        op == J_OP,
        op == SB_OP,        // 4..0 are the stores
        op == SH_OP,
        op == SW_OP,
        op == SWL_OP,
        op == SWR_OP
    };

    assign func_raw = {
        funct == ADD_FUNCT,
        funct == ADDU_FUNCT,
        funct == SUB_FUNCT,
        funct == SUBU_FUNCT,
        funct == SLT_FUNCT,
        funct == SLTU_FUNCT,
        funct == AND_FUNCT,
        funct == NOR_FUNCT,
        funct == OR_FUNCT,
        funct == XOR_FUNCT,
        funct == SLLV_FUNCT,
        funct == SLL_FUNCT,
        funct == SRAV_FUNCT,
        funct == SRA_FUNCT,
        funct == SRLV_FUNCT,
        funct == SRL_FUNCT,
        funct == JALR_FUNCT,
        funct == MFHI_FUNCT,
        funct == MFLO_FUNCT,
        funct == DIV_FUNCT,
        funct == DIVU_FUNCT,
        funct == MUL_FUNCT,
        funct == MULT_FUNCT,
        funct == MULTU_FUNCT,
        funct == JR_FUNCT,
        funct == MTHI_FUNCT,
        funct == MTLO_FUNCT,
        funct == BREAK_FUNCT,
        funct == SYSCALL_FUNCT,
        funct == ERET_FUNCT
    };

    // funct codes repeat across opcode spaces, so each bit only counts under its own opcode
    assign co_ctx     = op_codes[27] & inst[25] & (inst[24:6] == '0);
    assign func_mask  = {{21{op_codes[29]}}, op_codes[28], {7{op_codes[29]}}, co_ctx};
    assign func_codes = func_raw & func_mask;

    assign tlbp  = co_ctx & (funct == TLBP_FUNCT);
    assign tlbr  = co_ctx & (funct == TLBR_FUNCT);
    assign tlbwi = co_ctx & (funct == TLBWI_FUNCT);

    assign mfc0      = op_codes[27] & (rs == MFC0_RS) & (inst[10:3] == '0);
    assign mtc0      = op_codes[27] & (rs == MTC0_RS) & (inst[10:3] == '0);
    assign regimm_ok = op_codes[26] & ((rt == BGEZ_RT) | (rt == BLTZ_RT) |
                                       (rt == BGEZAL_RT) | (rt == BLTZAL_RT));
    assign link      = (op_codes[26] & ((rt == BGEZAL_RT) | (rt == BLTZAL_RT))) | op_codes[10];

    assign r_writer = (|func_codes[29:11]) | func_codes[8];   // ALU ops, jalr, mfhi/mflo, mul
    assign i_writer = (|op_codes[25:11]) | mfc0;

    // anything that writes no register decodes to register 0
    assign w_dst = r_writer ? inst[15:11] :
                   i_writer ? rt          :
                   link     ? 5'd31       : 5'd0;

    always_comb begin
        dec.op_codes    = op_codes;
        dec.func_codes  = func_codes;
        dec.rs          = rs;
        dec.rt          = rt;
        dec.rd          = inst[15:11];
        dec.sa          = inst[10:6];
        dec.imme        = inst[15:0];
        dec.j_imme      = inst[25:0];
        dec.w_reg_dst   = w_dst;
        dec.w_reg_ena   = (w_dst != 5'd0);
        dec.is_branch   = (|op_codes[9:6]) | op_codes[26];
        dec.is_j_imme   = op_codes[10] | op_codes[5];
        dec.is_jr       = func_codes[13] | func_codes[5];
        dec.is_ls       = (|op_codes[17:11]) | (|op_codes[4:0]);
        dec.is_mul      = func_codes[8];
        dec.is_cop0     = op_codes[27] | func_codes[2] | func_codes[1];
        dec.is_tlbp     = tlbp;
        dec.is_tlbr     = tlbr;
        dec.is_tlbwi    = tlbwi;
        dec.is_check_ov = func_codes[29] | func_codes[27] | op_codes[25];
        dec.is_hilo     = (|func_codes[12:9]) | (|func_codes[7:6]) | (|func_codes[4:3]);
        dec.is_ri       = ~((|func_codes) | (|op_codes[25:0]) | regimm_ok |
                            mfc0 | mtc0 | tlbp | tlbr | tlbwi);
    end

endmodule

`default_nettype wire

// ==== idu_ctrl.sv ====
`default_nettype none

module idu_ctrl import id_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire id_dec_t  dec,
    input  wire logic     inst_valid,
    input  wire load_hz_t load_hz,
    input  wire logic     flush,
    output logic          stall,
    output logic          capture,
    output logic          out_valid
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_HOLD
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   hz_match;

    // a load in execute has no data yet for a source read here
    assign hz_match = (load_hz.dst == dec.rs) || (load_hz.dst == dec.rt);
    assign stall    = inst_valid && load_hz.valid && (load_hz.dst != '0) && hz_match;
    assign capture  = inst_valid && !stall && !flush;

    always_comb begin
        if (flush)
            state_nxt = ST_IDLE;    // flush wins over capture
        else if (stall)
            state_nxt = ST_HOLD;    // upstream keeps the instruction
        else if (capture)
            state_nxt = ST_ISSUE;
        else
            state_nxt = ST_IDLE;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= ST_IDLE;
        else
            state <= state_nxt;
    end

    assign out_valid = (state == ST_ISSUE);

    a_dec_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid |-> $onehot0(dec.op_codes) && $onehot0(dec.func_codes));

    a_reset_quiet: assert property (@(posedge clk)
        $rose(rst_n) |-> !stall && !out_valid);

endmodule

`default_nettype wire

// ==== idu_operand.sv ====
`default_nettype none

module idu_operand import id_pkg::*; #(
    parameter bit WB_BYPASS = 1'b1
) (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire id_dec_t   dec,
    input  wire wb_t       wb,
    input  wire word_t     rs_data,
    input  wire word_t     rt_data,
    output reg_addr_t      rs_addr,
    output reg_addr_t      rt_addr,
    input  wire logic      capture,
    output id_ex_t         id_ex
);
    word_t  imm_ext;
    logic   zero_ext;
    id_ex_t id_ex_nxt;

    function automatic word_t fwd(input wb_t w, input reg_addr_t addr, input word_t rf_data);
        if (WB_BYPASS && w.ena && w.dst != '0 && w.dst == addr)
            return w.data;   // value being written this cycle
        return rf_data;
    endfunction

    assign rs_addr  = dec.rs;
    assign rt_addr  = dec.rt;
    assign zero_ext = dec.op_codes[ANDI_BIT] | dec.op_codes[ORI_BIT] | dec.op_codes[XORI_BIT];

    always_comb begin
        if (dec.op_codes[LUI_BIT])
            imm_ext = {dec.imme, 16'h0000};
        else if (zero_ext)
            imm_ext = {16'h0000, dec.imme};
        else
            imm_ext = {{16{dec.imme[15]}}, dec.imme};
    end

    always_comb begin
        id_ex_nxt.dec     = dec;
        id_ex_nxt.rs_val  = fwd(wb, dec.rs, rs_data);
        id_ex_nxt.rt_val  = fwd(wb, dec.rt, rt_data);
        id_ex_nxt.imm_ext = imm_ext;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            id_ex <= '0;
        else if (capture)
            id_ex <= id_ex_nxt;   // held otherwise, out_valid tells execute whether to use it
    end

endmodule

`default_nettype wire

// ==== idu_patterns.hex ====
// inst iv fl we wdst wdata lv ldst / exp: stall out_valid w_reg_dst w_reg_ena flags rs rt imm
// flags: branch j_imme jr ls mul cop0 tlbp tlbr tlbwi check_ov ri hilo (bit 11 down to 0)
00000000 0 0 1 01 11111111 0 00 0 0 00 0 000 00000000 00000000 00000000
00000000 0 0 1 02 80000002 0 00 0 0 00 0 000 00000000 00000000 00000000
00000000 0 0 1 08 0000abcd 0 00 0 0 00 0 000 00000000 00000000 00000000
00221820 1 0 0 00 00000000 0 00 0 0 00 0 000 00000000 00000000 00000000
8d05fffc 1 0 0 00 00000000 0 00 0 1 03 1 004 11111111 80000002 00001820
ac430008 1 0 0 00 00000000 0 00 0 1 05 1 100 0000abcd 00000000 fffffffc
10228000 1 0 0 00 00000000 0 00 0 1 00 0 100 80000002 00000000 00000008
0c000100 1 0 0 00 00000000 0 00 0 1 00 0 800 11111111 80000002 ffff8000
0bffffff 1 0 0 00 00000000 0 00 0 1 1f 1 400 00000000 00000000 00000100
00200008 1 0 0 00 00000000 0 00 0 1 00 0 400 00000000 00000000 ffffffff
00402009 1 0 0 00 00000000 0 00 0 1 00 0 200 11111111 00000000 00000008
70283002 1 0 0 00 00000000 0 00 0 1 04 1 200 80000002 00000000 00002009
00220018 1 0 0 00 00000000 0 00 0 1 06 1 080 11111111 0000abcd 00003002
00003810 1 0 0 00 00000000 0 00 0 1 00 0 001 11111111 80000002 00000018
40096000 1 0 0 00 00000000 0 00 0 1 07 1 001 00000000 00000000 00003810
40816000 1 0 0 00 00000000 0 00 0 1 09 1 040 00000000 00000000 00006000
0000000c 1 0 0 00 00000000 0 00 0 1 00 0 040 00000000 11111111 00006000
42000008 1 0 0 00 00000000 0 00 0 1 00 0 040 00000000 00000000 0000000c
42000001 1 0 0 00 00000000 0 00 0 1 00 0 060 00000000 00000000 00000008
42000002 1 0 0 00 00000000 0 00 0 1 00 0 050 00000000 00000000 00000001
fc000000 1 0 0 00 00000000 0 00 0 1 00 0 048 00000000 00000000 00000002
302a8001 1 0 0 00 00000000 0 00 0 1 00 0 002 00000000 00000000 00000000
3c0b8001 1 0 0 00 00000000 0 00 0 1 0a 1 000 11111111 00000000 00008001
20200005 1 0 0 00 00000000 0 00 0 1 0b 1 000 00000000 00000000 80010000
01a06021 1 0 1 0d deadbeef 0 00 0 1 00 0 004 11111111 00000000 00000005
01a07025 1 0 1 00 ffffffff 0 00 0 1 0c 1 000 deadbeef 00000000 00006021
00a11820 1 0 0 00 00000000 1 05 1 1 0e 1 000 deadbeef 00000000 00007025
00a11820 1 0 0 00 00000000 0 00 0 0 00 0 000 00000000 00000000 00000000
00027822 1 0 0 00 00000000 1 00 0 1 03 1 004 00000000 11111111 00001820
00027822 0 0 0 00 00000000 1 02 0 1 0f 1 004 00000000 80000002 00007822
00027822 1 0 0 00 00000000 1 02 1 0 00 0 000 00000000 00000000 00000000
00027822 1 1 0 00 00000000 0 00 0 0 00 0 000 00000000 00000000 00000000
34308000 1 0 0 00 00000000 1 09 0 0 00 0 000 00000000 00000000 00000000
00000000 0 0 0 00 00000000 0 00 0 1 10 1 000 11111111 00000000 00008000
04300004 1 0 0 00 00000000 0 00 0 0 00 0 000 00000000 00000000 00000000
00000000 0 0 0 00 00000000 0 00 0 1 1f 1 800 11111111 00000000 00000004
00000000 0 0 0 00 00000000 0 00 0 0 00 0 000 00000000 00000000 00000000
00000000 f 0 0 00 00000000 0 00 0 0 00 0 000 00000000 00000000 00000000

// ==== idu_regfile.sv ====
`default_nettype none

module idu_regfile import id_pkg::*; #(
    parameter bit WB_BYPASS = 1'b1
) (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire wb_t       wb,
    input  wire reg_addr_t rs_addr,
    input  wire reg_addr_t rt_addr,
    output word_t          rs_data,
    output word_t          rt_data
);
    word_t regs [31:1];   // register 0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (wb.ena && wb.dst != '0) begin
            regs[wb.dst] <= wb.data;
        end
    end

    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

// ==== idu_top.sv ====
`default_nettype none

module idu_top import id_pkg::*; #(
    parameter bit WB_BYPASS = 1'b1
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire inst_t    inst,
    input  wire logic     inst_valid,
    input  wire wb_t      wb,
    input  wire load_hz_t load_hz,
    input  wire logic     flush,
    output logic          stall,
    output logic          out_valid,
    output id_ex_t        id_ex
);
    id_dec_t   dec;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;
    logic      capture;

    idu_1 i_idu_1 (
        .inst (inst),
        .dec  (dec)
    );

    idu_ctrl i_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .dec        (dec),
        .inst_valid (inst_valid),
        .load_hz    (load_hz),
        .flush      (flush),
        .stall      (stall),
        .capture    (capture),
        .out_valid  (out_valid)
    );

    idu_regfile #(
        .WB_BYPASS (WB_BYPASS)
    ) i_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb      (wb),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    idu_operand #(
        .WB_BYPASS (WB_BYPASS)
    ) i_operand (
        .clk     (clk),
        .rst_n   (rst_n),
        .dec     (dec),
        .wb      (wb),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .capture (capture),
        .id_ex   (id_ex)
    );

endmodule

`default_nettype wire

// ==== tb_idu.sv ====
`default_nettype none

module tb_idu import id_pkg::*; ();
    localparam int VEC_WORDS   = 16;
    localparam int MAX_VECS    = 64;
    localparam int NUM_VECS    = 37;
    localparam int RST_TIMEOUT = 20;
    localparam int SIM_CYCLES  = 2000;

    logic     clk;
    logic     rst_n;
    inst_t    inst;
    logic     inst_valid;
    wb_t      wb;
    load_hz_t load_hz;
    logic     flush;
    logic     stall;
    logic     out_valid;
    id_ex_t   id_ex;

    logic [31:0] vec_mem [0:VEC_WORDS*MAX_VECS-1];
    integer      seed = 32'h5d51_5b71;
    int          num_vecs;
    int          cycles;
    logic        found;

    idu_top #(
        .WB_BYPASS (1'b1)
    ) i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst       (inst),
        .inst_valid (inst_valid),
        .wb         (wb),
        .load_hz    (load_hz),
        .flush      (flush),
        .stall      (stall),
        .out_valid  (out_valid),
        .id_ex      (id_ex)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("** Error %s: got %0h, expected %0h", name, got, exp));
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            report_failure($sformatf("** Error %s: got %08h, expected %08h", name, got, exp));
    endtask

    task automatic check_dec(input string name, input id_dec_t got, input inst_t exp_inst,
                             input reg_addr_t exp_dst, input logic exp_ena,
                             input logic [11:0] exp_flags);
        logic [11:0] got_flags;
        got_flags = {got.is_branch, got.is_j_imme, got.is_jr, got.is_ls, got.is_mul,
                     got.is_cop0, got.is_tlbp, got.is_tlbr, got.is_tlbwi, got.is_check_ov,
                     got.is_ri, got.is_hilo};
        // register fields and immediates are fixed slices of the instruction word
        if ({got.rs, got.rt, got.imme} !== exp_inst[25:0])
            report_failure($sformatf("** Error %s rs/rt/imme: got %07h, expected %07h",
                                     name, {got.rs, got.rt, got.imme}, exp_inst[25:0]));
        if ({got.rd, got.sa} !== exp_inst[15:6])
            report_failure($sformatf("** Error %s rd/sa: got %03h, expected %03h",
                                     name, {got.rd, got.sa}, exp_inst[15:6]));
        if (got.j_imme !== exp_inst[25:0])
            report_failure($sformatf("** Error %s.j_imme: got %07h, expected %07h",
                                     name, got.j_imme, exp_inst[25:0]));
        if (got.w_reg_dst !== exp_dst)
            report_failure($sformatf("** Error %s.w_reg_dst: got %02h, expected %02h",
                                     name, got.w_reg_dst, exp_dst));
        check_bit({name, ".w_reg_ena"}, got.w_reg_ena, exp_ena);
        if (got_flags !== exp_flags)
            report_failure($sformatf("** Error %s flags: got %03h, expected %03h",
                                     name, got_flags, exp_flags));
    endtask

    task automatic apply_vector(input int v);
        int base;
        base = v * VEC_WORDS;
        @(posedge clk);
        inst          <= vec_mem[base];
        inst_valid    <= vec_mem[base+1][0];
        flush         <= vec_mem[base+2][0];
        wb.ena        <= vec_mem[base+3][0];
        wb.dst        <= vec_mem[base+4][4:0];
        wb.data       <= vec_mem[base+5];
        load_hz.valid <= vec_mem[base+6][0];
        load_hz.dst   <= vec_mem[base+7][4:0];
    endtask

    // expected id_ex belongs to the instruction of the vector before
    task automatic check_vector(input int v);
        int    base;
        string tag;
        base = v * VEC_WORDS;
        tag  = $sformatf("vec %0d", v);
        check_bit({tag, " stall"}, stall, vec_mem[base+8][0]);
        check_bit({tag, " out_valid"}, out_valid, vec_mem[base+9][0]);
        if (vec_mem[base+9][0]) begin
            check_dec({tag, " id_ex.dec"}, id_ex.dec, vec_mem[base-VEC_WORDS],
                      vec_mem[base+10][4:0], vec_mem[base+11][0], vec_mem[base+12][11:0]);
            check_word({tag, " id_ex.rs_val"}, id_ex.rs_val, vec_mem[base+13]);
            check_word({tag, " id_ex.rt_val"}, id_ex.rt_val, vec_mem[base+14]);
            check_word({tag, " id_ex.imm_ext"}, id_ex.imm_ext, vec_mem[base+15]);
        end
    endtask

    initial begin
        for (int c = 0; c < SIM_CYCLES; c++)
            @(posedge clk);
        report_failure("simulation ran past its cycle limit without finishing");
    end

    initial begin
        rst_n      = 1'b0;
        inst       = '0;
        inst_valid = 1'b0;
        wb         = '0;
        load_hz    = '0;
        flush      = 1'b0;
        $readmemh("idu_patterns.hex", vec_mem);

        // an inst_valid word of f marks the end of the vectors
        found    = 1'b0;
        num_vecs = 0;
        for (int v = 0; v < MAX_VECS && !found; v++) begin
            if (vec_mem[v*VEC_WORDS+1] == 32'hf) begin
                found    = 1'b1;
                num_vecs = v;
            end
        end
        if (!found)
            report_failure("pattern file has no end marker within the vector limit");
        if (num_vecs < NUM_VECS)
            report_failure("pattern file ran out of vectors before the expected count");

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        cycles = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > RST_TIMEOUT)
                report_failure("reset release was not seen in time");
        end

        @(negedge clk);
        check_bit("stall after reset", stall, 1'b0);
        check_bit("out_valid after reset", out_valid, 1'b0);
        check_dec("id_ex.dec after reset", id_ex.dec, '0, '0, 1'b0, '0);
        check_word("id_ex.rs_val after reset", id_ex.rs_val, '0);
        check_word("id_ex.rt_val after reset", id_ex.rt_val, '0);
        check_word("id_ex.imm_ext after reset", id_ex.imm_ext, '0);

        for (int v = 0; v < num_vecs; v++) begin
            apply_vector(v);
            @(negedge clk);
            check_vector(v);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
id_pkg.sv
idu_1.sv
idu_regfile.sv
idu_operand.sv
idu_ctrl.sv
idu_top.sv
tb_idu.sv
